/* filelist.f */
+incdir+include
verilog/core_pkg.sv
verilog/fetch_unit.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/load_store_unit.sv
verilog/bus_arbiter.sv
verilog/cpu_top.sv
verification/tb_sram_model.sv
verification/tb_cpu_top.sv

/* Makefile */
TOP := tb_cpu_top
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verification/tb_cpu_top.sv */
`include "core_consts.svh"

module tb_cpu_top;

    localparam int unsigned RNG_SEED   = 32'hc470c57f;
    localparam int          MEM_WORDS  = 1024;
    localparam int          PROG_LEN   = 28;
    localparam int          N_COMMITS  = 23;
    // 40 cycles for each program instruction
    localparam int          MAX_CYCLES = PROG_LEN * 40;

    logic        aclk;
    logic        aresetn;
    logic        bus_req;
    logic        bus_wr;
    logic [1:0]  bus_size;
    logic [31:0] bus_addr;
    logic [3:0]  bus_wstrb;
    logic [31:0] bus_wdata;
    logic        bus_addr_ok;
    logic        bus_data_ok;
    logic [31:0] bus_rdata;
    logic        debug_wb_valid;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;
    logic [31:0] debug_wb_inst;

    logic [31:0] prog [PROG_LEN];
    logic [31:0] exp_pc [N_COMMITS];
    logic [31:0] exp_inst [N_COMMITS];
    logic        exp_wen [N_COMMITS];
    logic [4:0]  exp_wnum [N_COMMITS];
    logic [31:0] exp_wdata [N_COMMITS];
    int          n_built = 0;
    int          commit_idx;
    int          cur;
    int          cycle_count = 0;
    int          mismatch_count = 0;
    int          failure_count = 0;
    logic        timed_out = 1'b0;
    logic        req_pending;
    logic        first_seen;

    cpu_top DUT (.*);

    tb_sram_model #(.SEED(RNG_SEED), .DEPTH(MEM_WORDS)) u_sram (.*);

    initial aclk = 1'b0;
    always #4 aclk = ~aclk;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("MISMATCH %s: got 0x%08h expected 0x%08h at %0t", name, got, want, $time);
        mismatch_count++;
    endtask

    task automatic report_failure(input string what);
        $display("failure: %s at %0t", what, $time);
        failure_count++;
    endtask

    function automatic logic [3:0] strobe_for(input logic [1:0] size, input logic [1:0] lane);
        if (size == 2'd2)
            return 4'hf;
        return 4'b0001 << lane;
    endfunction

    task automatic add_commit(input int off, input logic wen, input logic [4:0] wnum,
                              input logic [31:0] wdata);
        exp_pc[n_built]    = `CORE_RESET_PC + off;
        exp_inst[n_built]  = prog[off / 4];
        exp_wen[n_built]   = wen;
        exp_wnum[n_built]  = wnum;
        exp_wdata[n_built] = wdata;
        n_built++;
    endtask

    task automatic load_program();
        prog[0]  = 32'h14380004;  // lu12i.w r4, 0x1c000
        prog[1]  = 32'h02848c05;  // addi.w  r5, r0, 0x123
        prog[2]  = 32'h02bffc06;  // addi.w  r6, r0, -1
        prog[3]  = 32'h001018a7;  // add.w   r7, r5, r6
        prog[4]  = 32'h001118a8;  // sub.w   r8, r5, r6
        prog[5]  = 32'h15135789;  // lu12i.w r9, 0x89abc
        prog[6]  = 32'h02979d29;  // addi.w  r9, r9, 0x5e7
        prog[7]  = 32'h29880089;  // st.w    r9, r4, 0x200
        prog[8]  = 32'h2888008a;  // ld.w    r10, r4, 0x200
        prog[9]  = 32'h0282940c;  // addi.w  r12, r0, 0xa5
        prog[10] = 32'h2908048c;  // st.b    r12, r4, 0x201
        prog[11] = 32'h2888008d;  // ld.w    r13, r4, 0x200
        prog[12] = 32'h2808048e;  // ld.b    r14, r4, 0x201
        prog[13] = 32'h2a08048f;  // ld.bu   r15, r4, 0x201
        prog[14] = 32'h02801400;  // addi.w  r0, r0, 5
        prog[15] = 32'h00101410;  // add.w   r16, r0, r5
        prog[16] = 32'h5c000ca6;  // bne     r5, r6, +12
        prog[17] = 32'h02800411;  // wrong path
        prog[18] = 32'h02800811;  // wrong path
        prog[19] = 32'h58000cb0;  // beq     r5, r16, +12
        prog[20] = 32'h02800c11;  // wrong path
        prog[21] = 32'h02801011;  // wrong path
        prog[22] = 32'h580008a6;  // beq     r5, r6, +8 (not taken)
        prog[23] = 32'h54000c00;  // bl      +12
        prog[24] = 32'h02801411;  // wrong path
        prog[25] = 32'h02801811;  // wrong path
        prog[26] = 32'h00100032;  // add.w   r18, r1, r0
        prog[27] = 32'h58000000;  // beq     r0, r0, 0 (spin)
        // fill derived from the full byte address
        for (int i = 0; i < MEM_WORDS; i++) begin
            u_sram.mem[i] = {20'h1c000, 10'(i), 2'b00} ^ 32'h3c5a96e1;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            u_sram.mem[i] = prog[i];
        end
    endtask

    task automatic build_expected();
        add_commit(32'h00, 1'b1, 5'd4,  32'h1c000000);
        add_commit(32'h04, 1'b1, 5'd5,  32'h00000123);
        add_commit(32'h08, 1'b1, 5'd6,  32'hffffffff);
        add_commit(32'h0c, 1'b1, 5'd7,  32'h00000122);
        add_commit(32'h10, 1'b1, 5'd8,  32'h00000124);
        add_commit(32'h14, 1'b1, 5'd9,  32'h89abc000);
        add_commit(32'h18, 1'b1, 5'd9,  32'h89abc5e7);
        add_commit(32'h1c, 1'b0, 5'd0,  32'h0);
        add_commit(32'h20, 1'b1, 5'd10, 32'h89abc5e7);
        add_commit(32'h24, 1'b1, 5'd12, 32'h000000a5);
        add_commit(32'h28, 1'b0, 5'd0,  32'h0);
        // only byte 1 replaced by the st.b
        add_commit(32'h2c, 1'b1, 5'd13, 32'h89aba5e7);
        add_commit(32'h30, 1'b1, 5'd14, 32'hffffffa5);
        add_commit(32'h34, 1'b1, 5'd15, 32'h000000a5);
        add_commit(32'h38, 1'b1, 5'd0,  32'h00000005);
        add_commit(32'h3c, 1'b1, 5'd16, 32'h00000123);
        add_commit(32'h40, 1'b0, 5'd0,  32'h0);
        add_commit(32'h4c, 1'b0, 5'd0,  32'h0);
        add_commit(32'h58, 1'b0, 5'd0,  32'h0);
        add_commit(32'h5c, 1'b1, 5'd1,  32'h1c000060);
        add_commit(32'h68, 1'b1, 5'd18, 32'h1c000060);
        add_commit(32'h6c, 1'b0, 5'd0,  32'h0);
        add_commit(32'h6c, 1'b0, 5'd0,  32'h0);
    endtask

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (!aresetn) begin
            commit_idx  <= 0;
            req_pending <= 1'b0;
            first_seen  <= 1'b0;
        end else begin
            if (debug_wb_valid) begin
                commit_idx <= commit_idx + 1;
            end
            if (bus_req && bus_addr_ok) begin
                req_pending <= 1'b1;
                first_seen  <= 1'b1;
            end else if (bus_data_ok) begin
                req_pending <= 1'b0;
            end
        end
    end

    assign cur = (commit_idx < N_COMMITS) ? commit_idx : N_COMMITS - 1;

    reset_quiet_a: assert property (@(posedge aclk)
        !aresetn && cycle_count > 0 |-> !bus_req && !debug_wb_valid)
        else report_failure("bus_req or debug_wb_valid high during reset");

    first_read_a: assert property (@(posedge aclk) disable iff (!aresetn)
        bus_req && bus_addr_ok && !first_seen |-> !bus_wr)
        else report_failure("first accepted request is a write");

    first_addr_a: assert property (@(posedge aclk) disable iff (!aresetn)
        bus_req && bus_addr_ok && !first_seen |-> bus_addr == `CORE_RESET_PC)
        else report_mismatch("bus_addr", $sampled(bus_addr), `CORE_RESET_PC);

    req_hold_a: assert property (@(posedge aclk) disable iff (!aresetn)
        bus_req && !bus_addr_ok |=> bus_req && $stable(bus_addr) && $stable(bus_wr)
            && $stable(bus_size) && $stable(bus_wstrb) && $stable(bus_wdata))
        else report_failure("request changed while waiting for bus_addr_ok");

    strobe_a: assert property (@(posedge aclk) disable iff (!aresetn)
        bus_req |-> bus_wstrb == strobe_for(bus_size, bus_addr[1:0]))
        else report_mismatch("bus_wstrb", 32'($sampled(bus_wstrb)),
            32'(strobe_for($sampled(bus_size), $sampled(bus_addr[1:0]))));

    byte_lanes_a: assert property (@(posedge aclk) disable iff (!aresetn)
        bus_req && bus_wr && bus_size == 2'd0 |-> bus_wdata == {4{bus_wdata[7:0]}})
        else report_failure("byte store data not copied to every lane");

    one_outstanding_a: assert property (@(posedge aclk) disable iff (!aresetn)
        bus_req |-> !req_pending)
        else report_failure("bus_req raised while a response was pending");

    resp_after_req_a: assert property (@(posedge aclk) disable iff (!aresetn)
        bus_data_ok |-> req_pending)
        else report_failure("bus_data_ok without an accepted request");

    commit_pc_a: assert property (@(posedge aclk) disable iff (!aresetn)
        debug_wb_valid |-> debug_wb_pc == exp_pc[cur])
        else report_mismatch("debug_wb_pc", $sampled(debug_wb_pc), $sampled(exp_pc[cur]));

    commit_inst_a: assert property (@(posedge aclk) disable iff (!aresetn)
        debug_wb_valid |-> debug_wb_inst == exp_inst[cur])
        else report_mismatch("debug_wb_inst", $sampled(debug_wb_inst),
            $sampled(exp_inst[cur]));

    commit_wen_a: assert property (@(posedge aclk) disable iff (!aresetn)
        debug_wb_valid |-> debug_wb_rf_wen == {4{exp_wen[cur]}})
        else report_mismatch("debug_wb_rf_wen", 32'($sampled(debug_wb_rf_wen)),
            32'({4{$sampled(exp_wen[cur])}}));

    commit_wnum_a: assert property (@(posedge aclk) disable iff (!aresetn)
        debug_wb_valid && exp_wen[cur] |-> debug_wb_rf_wnum == exp_wnum[cur])
        else report_mismatch("debug_wb_rf_wnum", 32'($sampled(debug_wb_rf_wnum)),
            32'($sampled(exp_wnum[cur])));

    commit_wdata_a: assert property (@(posedge aclk) disable iff (!aresetn)
        debug_wb_valid && exp_wen[cur] |-> debug_wb_rf_wdata == exp_wdata[cur])
        else report_mismatch("debug_wb_rf_wdata", $sampled(debug_wb_rf_wdata),
            $sampled(exp_wdata[cur]));

    initial begin
        aresetn = 1'b0;
        load_program();
        build_expected();
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        while (commit_idx < N_COMMITS && cycle_count < MAX_CYCLES) begin
            @(negedge aclk);
        end
        if (commit_idx < N_COMMITS) begin
            timed_out = 1'b1;
            $display("timeout: only %0d of %0d commits after %0d cycles",
                     commit_idx, N_COMMITS, cycle_count);
        end
        $display("summary: %0d mismatches, %0d other failures, %0d of %0d commits",
                 mismatch_count, failure_count, commit_idx, N_COMMITS);
        if (mismatch_count == 0 && failure_count == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* verification/tb_sram_model.sv */
module tb_sram_model #(
    parameter int unsigned SEED  = 1,
    parameter int          DEPTH = 1024
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        bus_req,
    input  logic        bus_wr,
    input  logic [31:0] bus_addr,
    input  logic [3:0]  bus_wstrb,
    input  logic [31:0] bus_wdata,
    output logic        bus_addr_ok,
    output logic        bus_data_ok,
    output logic [31:0] bus_rdata
);

    // word array, filled by the testbench before reset release
    logic [31:0] mem [DEPTH];

    initial begin : responder
        int unsigned wait_cycles;
        int          idx;
        logic        acc_wr;
        logic [3:0]  acc_wstrb;
        logic [31:0] acc_wdata;
        bus_addr_ok = 1'b0;
        bus_data_ok = 1'b0;
        bus_rdata   = '0;
        void'($urandom(SEED));
        forever begin
            @(negedge aclk);
            bus_data_ok = 1'b0;
            if (aresetn && bus_req) begin
                // acceptance delay, request must hold meanwhile
                wait_cycles = $urandom_range(3, 0);
                repeat (wait_cycles) @(negedge aclk);
                bus_addr_ok = 1'b1;
                acc_wr      = bus_wr;
                acc_wstrb   = bus_wstrb;
                acc_wdata   = bus_wdata;
                idx         = int'((bus_addr >> 2) % DEPTH);
                @(negedge aclk);
                bus_addr_ok = 1'b0;
                // response delay after acceptance
                wait_cycles = $urandom_range(3, 0);
                repeat (wait_cycles) @(negedge aclk);
                if (acc_wr) begin
                    for (int b = 0; b < 4; b++) begin
                        if (acc_wstrb[b]) begin
                            mem[idx][8*b +: 8] = acc_wdata[8*b +: 8];
                        end
                    end
                    bus_rdata = '0;
                end else begin
                    // full word, lane select is the core's job
                    bus_rdata = mem[idx];
                end
                bus_data_ok = 1'b1;
            end
        end
    end

endmodule

/* verilog/cpu_top.sv */
module cpu_top (
    input  logic               aclk,
    input  logic               aresetn,
    output logic               bus_req,
    output logic               bus_wr,
    output logic [1:0]         bus_size,
    output core_pkg::word_t    bus_addr,
    output logic [3:0]         bus_wstrb,
    output core_pkg::word_t    bus_wdata,
    input  logic               bus_addr_ok,
    input  logic               bus_data_ok,
    input  core_pkg::word_t    bus_rdata,
    output logic               debug_wb_valid,
    output core_pkg::word_t    debug_wb_pc,
    output logic [3:0]         debug_wb_rf_wen,
    output core_pkg::reg_idx_t debug_wb_rf_wnum,
    output core_pkg::word_t    debug_wb_rf_wdata,
    output core_pkg::word_t    debug_wb_inst
);
    import core_pkg::*;

    // fetch side
    logic      fetch_req;
    word_t     fetch_addr;
    logic      fetch_addr_ok;
    logic      fetch_data_ok;
    word_t     fetch_rdata;
    logic      inst_valid;
    word_t     inst_word;
    word_t     inst_pc;
    logic      inst_take;
    logic      redirect;
    word_t     redirect_pc;

    // data side
    logic      mem_start;
    inst_op_e  mem_op;
    word_t     mem_addr;
    word_t     mem_wdata;
    logic      mem_done;
    word_t     mem_rdata;
    logic      data_req;
    logic      data_wr;
    mem_size_e data_size;
    word_t     data_addr;
    logic [3:0] data_wstrb;
    word_t     data_wdata;
    logic      data_addr_ok;
    logic      data_data_ok;
    word_t     data_rdata;

    fetch_unit u_fetch (.*);

    exec_unit u_exec (.*);

    load_store_unit u_lsu (.*);

    bus_arbiter u_arbiter (.*);

endmodule

/* verilog/bus_arbiter.sv */
module bus_arbiter (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                fetch_req,
    input  core_pkg::word_t     fetch_addr,
    input  logic                data_req,
    input  logic                data_wr,
    input  core_pkg::mem_size_e data_size,
    input  core_pkg::word_t     data_addr,
    input  logic [3:0]          data_wstrb,
    input  core_pkg::word_t     data_wdata,
    input  logic                bus_addr_ok,
    input  logic                bus_data_ok,
    input  core_pkg::word_t     bus_rdata,
    output logic                bus_req,
    output logic                bus_wr,
    output logic [1:0]          bus_size,
    output core_pkg::word_t     bus_addr,
    output logic [3:0]          bus_wstrb,
    output core_pkg::word_t     bus_wdata,
    output logic                fetch_addr_ok,
    output logic                fetch_data_ok,
    output core_pkg::word_t     fetch_rdata,
    output logic                data_addr_ok,
    output logic                data_data_ok,
    output core_pkg::word_t     data_rdata
);
    import core_pkg::*;

    bus_owner_e grant_q;
    bus_owner_e resp_owner;
    bus_owner_e cur;

    // a held grant sticks, otherwise data beats fetch on an idle bus
    always_comb begin
        cur = grant_q;
        if (grant_q == OWNER_NONE && resp_owner == OWNER_NONE) begin
            if (data_req) begin
                cur = OWNER_DATA;
            end else if (fetch_req) begin
                cur = OWNER_FETCH;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            grant_q    <= OWNER_NONE;
            resp_owner <= OWNER_NONE;
        end else if (bus_req && bus_addr_ok) begin
            grant_q    <= OWNER_NONE;
            resp_owner <= cur;
        end else begin
            grant_q <= cur;
            if (bus_data_ok) begin
                resp_owner <= OWNER_NONE;
            end
        end
    end

    assign bus_req   = (cur != OWNER_NONE);
    assign bus_wr    = (cur == OWNER_DATA) && data_wr;
    assign bus_size  = (cur == OWNER_DATA) ? data_size : SIZE_WORD;
    assign bus_addr  = (cur == OWNER_DATA) ? data_addr : fetch_addr;
    assign bus_wstrb = (cur == OWNER_DATA) ? data_wstrb : 4'hf;
    assign bus_wdata = (cur == OWNER_DATA) ? data_wdata : '0;

    assign fetch_addr_ok = bus_addr_ok && (cur == OWNER_FETCH);
    assign data_addr_ok  = bus_addr_ok && (cur == OWNER_DATA);
    assign fetch_data_ok = bus_data_ok && (resp_owner == OWNER_FETCH);
    assign data_data_ok  = bus_data_ok && (resp_owner == OWNER_DATA);
    assign fetch_rdata   = bus_rdata;
    assign data_rdata    = bus_rdata;

    resp_has_owner_a: assert property (@(posedge aclk) disable iff (!aresetn)
        bus_data_ok |-> resp_owner != OWNER_NONE);

endmodule

/* verilog/load_store_unit.sv */
module load_store_unit (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                mem_start,
    input  core_pkg::inst_op_e  mem_op,
    input  core_pkg::word_t     mem_addr,
    input  core_pkg::word_t     mem_wdata,
    input  logic                data_addr_ok,
    input  logic                data_data_ok,
    input  core_pkg::word_t     data_rdata,
    output logic                data_req,
    output logic                data_wr,
    output core_pkg::mem_size_e data_size,
    output core_pkg::word_t     data_addr,
    output logic [3:0]          data_wstrb,
    output core_pkg::word_t     data_wdata,
    output logic                mem_done,
    output core_pkg::word_t     mem_rdata
);
    import core_pkg::*;

    logic       is_word;
    logic       ld_signed;
    logic [7:0] lane_byte;
    word_t      load_val;

    assign is_word = (mem_op == OP_LD_W) || (mem_op == OP_ST_W);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            data_req <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= data_data_ok;
            if (mem_start) begin
                data_req <= 1'b1;
            end else if (data_addr_ok) begin
                data_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (mem_start) begin
            data_wr    <= (mem_op == OP_ST_W) || (mem_op == OP_ST_B);
            data_size  <= is_word ? SIZE_WORD : SIZE_BYTE;
            data_addr  <= mem_addr;
            data_wstrb <= is_word ? 4'hf : 4'b0001 << mem_addr[1:0];
            // byte store goes out on every lane
            data_wdata <= is_word ? mem_wdata : {4{mem_wdata[7:0]}};
            ld_signed  <= (mem_op == OP_LD_B);
        end
        if (data_data_ok) begin
            mem_rdata <= load_val;
        end
    end

    assign lane_byte = data_rdata[{data_addr[1:0], 3'b000} +: 8];

    always_comb begin
        if (data_size == SIZE_WORD) begin
            load_val = data_rdata;
        end else if (ld_signed) begin
            load_val = {{24{lane_byte[7]}}, lane_byte};
        end else begin
            load_val = {24'b0, lane_byte};
        end
    end

    data_strobe_shape_a: assert property (@(posedge aclk) disable iff (!aresetn)
        data_req |-> (data_size == SIZE_WORD) ? (data_wstrb == 4'hf) : $onehot(data_wstrb));

endmodule

/* verilog/exec_unit.sv */
module exec_unit (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               inst_valid,
    input  core_pkg::word_t    inst_word,
    input  core_pkg::word_t    inst_pc,
    input  logic               mem_done,
    input  core_pkg::word_t    mem_rdata,
    output logic               inst_take,
    output logic               redirect,
    output core_pkg::word_t    redirect_pc,
    output logic               mem_start,
    output core_pkg::inst_op_e mem_op,
    output core_pkg::word_t    mem_addr,
    output core_pkg::word_t    mem_wdata,
    output logic               debug_wb_valid,
    output core_pkg::word_t    debug_wb_pc,
    output logic [3:0]         debug_wb_rf_wen,
    output core_pkg::reg_idx_t debug_wb_rf_wnum,
    output core_pkg::word_t    debug_wb_rf_wdata,
    output core_pkg::word_t    debug_wb_inst
);
    import core_pkg::*;

    exec_state_e state;
    inst_op_e    op;
    reg_idx_t    rd;
    reg_idx_t    rj;
    reg_idx_t    rk;
    reg_idx_t    raddr2;
    word_t       imm;
    word_t       rj_val;
    word_t       r2_val;
    word_t       alu_res;
    logic        is_store;
    logic        is_mem;
    logic        taken;
    logic        wen_dec;
    logic        c_wen;
    logic        c_taken;
    reg_idx_t    c_wnum;
    word_t       c_wdata;
    word_t       c_target;
    word_t       c_pc;
    word_t       c_inst;

    inst_decoder u_decoder (
        .inst     (inst_word),
        .op       (op),
        .rd       (rd),
        .rj       (rj),
        .rk       (rk),
        .imm      (imm),
        .is_store (is_store)
    );

    // stores and branches read rd as their second operand
    assign raddr2 = (is_store || op == OP_BEQ || op == OP_BNE) ? rd : rk;

    reg_file u_reg_file (
        .aclk    (aclk),
        .aresetn (aresetn),
        .raddr1  (rj),
        .raddr2  (raddr2),
        .wen     (debug_wb_valid && c_wen),
        .waddr   (c_wnum),
        .wdata   (c_wdata),
        .rdata1  (rj_val),
        .rdata2  (r2_val)
    );

    assign is_mem = is_store || op == OP_LD_W || op == OP_LD_B || op == OP_LD_BU;

    always_comb begin
        alu_res = '0;
        taken   = 1'b0;
        wen_dec = 1'b1;
        case (op)
            OP_ADD_W:   alu_res = rj_val + r2_val;
            OP_SUB_W:   alu_res = rj_val - r2_val;
            OP_ADDI_W:  alu_res = rj_val + imm;
            OP_LU12I_W: alu_res = imm;
            OP_BL: begin
                alu_res = inst_pc + 32'd4;
                taken   = 1'b1;
            end
            OP_BEQ: begin
                taken   = (rj_val == r2_val);
                wen_dec = 1'b0;
            end
            OP_BNE: begin
                taken   = (rj_val != r2_val);
                wen_dec = 1'b0;
            end
            OP_ST_W, OP_ST_B, OP_INVALID: wen_dec = 1'b0;
            default: alu_res = '0;
        endcase
    end

    assign inst_take = (state == EX_IDLE) && inst_valid;
    assign mem_start = inst_take && is_mem;
    assign mem_op    = op;
    assign mem_addr  = rj_val + imm;
    assign mem_wdata = r2_val;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= EX_IDLE;
        end else begin
            case (state)
                EX_IDLE: begin
                    if (inst_valid) begin
                        state <= is_mem ? EX_MEM_WAIT : EX_COMMIT;
                    end
                end
                EX_MEM_WAIT: begin
                    if (mem_done) begin
                        state <= EX_COMMIT;
                    end
                end
                default: state <= EX_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (inst_take) begin
            c_pc     <= inst_pc;
            c_inst   <= inst_word;
            c_wen    <= wen_dec;
            c_wnum   <= rd;
            c_wdata  <= alu_res;
            c_taken  <= taken;
            c_target <= inst_pc + imm;
        end else if (mem_done) begin
            c_wdata <= mem_rdata;
        end
    end

    assign debug_wb_valid    = (state == EX_COMMIT);
    assign debug_wb_pc       = c_pc;
    assign debug_wb_rf_wen   = {4{c_wen}};
    assign debug_wb_rf_wnum  = c_wnum;
    assign debug_wb_rf_wdata = c_wdata;
    assign debug_wb_inst     = c_inst;
    assign redirect          = debug_wb_valid && c_taken;
    assign redirect_pc       = c_target;

    mem_done_in_wait_a: assert property (@(posedge aclk) disable iff (!aresetn)
        mem_done |-> state == EX_MEM_WAIT);

endmodule

/* verilog/reg_file.sv */
module reg_file (
    input  logic               aclk,
    input  logic               aresetn,
    input  core_pkg::reg_idx_t raddr1,
    input  core_pkg::reg_idx_t raddr2,
    input  logic               wen,
    input  core_pkg::reg_idx_t waddr,
    input  core_pkg::word_t    wdata,
    output core_pkg::word_t    rdata1,
    output core_pkg::word_t    rdata2
);
    import core_pkg::*;

    word_t regs [32];

    always_ff @(posedge aclk) begin
        if (aresetn && wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is wired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* verilog/inst_decoder.sv */
`include "core_consts.svh"

module inst_decoder (
    input  core_pkg::word_t    inst,
    output core_pkg::inst_op_e op,
    output core_pkg::reg_idx_t rd,
    output core_pkg::reg_idx_t rj,
    output core_pkg::reg_idx_t rk,
    output core_pkg::word_t    imm,
    output logic               is_store
);
    import core_pkg::*;

    word_t si12;
    word_t si20;
    word_t offs16;
    word_t offs26;

    assign si12   = {{20{inst[21]}}, inst[21:10]};
    assign si20   = {inst[24:5], 12'b0};
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    // offs26 keeps its high part in the low bits of the word
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    always_comb begin
        if (inst[31:15] == `OPC_ADD_W)
            op = OP_ADD_W;
        else if (inst[31:15] == `OPC_SUB_W)
            op = OP_SUB_W;
        else if (inst[31:22] == `OPC_ADDI_W)
            op = OP_ADDI_W;
        else if (inst[31:22] == `OPC_LD_W)
            op = OP_LD_W;
        else if (inst[31:22] == `OPC_LD_B)
            op = OP_LD_B;
        else if (inst[31:22] == `OPC_LD_BU)
            op = OP_LD_BU;
        else if (inst[31:22] == `OPC_ST_W)
            op = OP_ST_W;
        else if (inst[31:22] == `OPC_ST_B)
            op = OP_ST_B;
        else if (inst[31:25] == `OPC_LU12I_W)
            op = OP_LU12I_W;
        else if (inst[31:26] == `OPC_BEQ)
            op = OP_BEQ;
        else if (inst[31:26] == `OPC_BNE)
            op = OP_BNE;
        else if (inst[31:26] == `OPC_BL)
            op = OP_BL;
        else
            op = OP_INVALID;
    end

    always_comb begin
        case (op)
            OP_ADDI_W, OP_LD_W, OP_LD_B, OP_LD_BU, OP_ST_W, OP_ST_B: imm = si12;
            OP_LU12I_W:     imm = si20;
            OP_BEQ, OP_BNE: imm = offs16;
            OP_BL:          imm = offs26;
            default:        imm = '0;
        endcase
    end

    assign rd       = (op == OP_BL) ? `LINK_REG : inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];
    assign is_store = (op == OP_ST_W) || (op == OP_ST_B);

endmodule

/* verilog/fetch_unit.sv */
`include "core_consts.svh"

module fetch_unit (
    input  logic            aclk,
    input  logic            aresetn,
    input  logic            inst_take,
    input  logic            redirect,
    input  core_pkg::word_t redirect_pc,
    input  logic            fetch_addr_ok,
    input  logic            fetch_data_ok,
    input  core_pkg::word_t fetch_rdata,
    output logic            fetch_req,
    output core_pkg::word_t fetch_addr,
    output logic            inst_valid,
    output core_pkg::word_t inst_word,
    output core_pkg::word_t inst_pc
);
    import core_pkg::*;

    word_t pc;
    word_t start_pc;
    logic  inflight;
    logic  discard;
    logic  issue;

    // a redirect in the issue cycle goes straight to the target
    assign start_pc = redirect ? redirect_pc : pc;
    assign issue    = !fetch_req && !inflight && !inst_valid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pc         <= `CORE_RESET_PC;
            fetch_req  <= 1'b0;
            inflight   <= 1'b0;
            discard    <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            if (issue) begin
                fetch_req <= 1'b1;
                pc        <= start_pc + 32'd4;
            end else if (redirect) begin
                pc <= redirect_pc;
            end
            if (fetch_req && fetch_addr_ok) begin
                fetch_req <= 1'b0;
                inflight  <= 1'b1;
            end
            if (fetch_data_ok) begin
                inflight <= 1'b0;
                discard  <= 1'b0;
            end
            // wrong-path fetch still outstanding, drop its answer later
            if (redirect && (fetch_req || inflight) && !fetch_data_ok) begin
                discard <= 1'b1;
            end
            if (redirect || inst_take) begin
                inst_valid <= 1'b0;
            end else if (fetch_data_ok && !discard) begin
                inst_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (issue) begin
            fetch_addr <= start_pc;
        end
        if (fetch_data_ok) begin
            inst_word <= fetch_rdata;
            inst_pc   <= fetch_addr;
        end
    end

    fetch_addr_hold_a: assert property (@(posedge aclk) disable iff (!aresetn)
        fetch_req && !fetch_addr_ok |=> fetch_req && $stable(fetch_addr));

endmodule

/* verilog/core_pkg.sv */
`include "core_consts.svh"

package core_pkg;

    typedef logic [`WORD_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        OP_ADD_W,
        OP_SUB_W,
        OP_ADDI_W,
        OP_LU12I_W,
        OP_LD_W,
        OP_LD_B,
        OP_LD_BU,
        OP_ST_W,
        OP_ST_B,
        OP_BEQ,
        OP_BNE,
        OP_BL,
        OP_INVALID
    } inst_op_e;

    // same values as the bus size field
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {EX_IDLE, EX_COMMIT, EX_MEM_WAIT} exec_state_e;

    typedef enum logic [1:0] {OWNER_NONE, OWNER_FETCH, OWNER_DATA} bus_owner_e;

endpackage

/* include/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define CORE_RESET_PC 32'h1c000000
`define WORD_W        32
`define REG_ADDR_W    5
`define LINK_REG      5'd1

// major opcode fields, compared against inst[31:15], [31:22], [31:25] or [31:26]
`define OPC_ADD_W     17'h00020
`define OPC_SUB_W     17'h00022
`define OPC_ADDI_W    10'h00a
`define OPC_LD_B      10'h0a0
`define OPC_LD_W      10'h0a2
`define OPC_ST_B      10'h0a4
`define OPC_ST_W      10'h0a6
`define OPC_LD_BU     10'h0a8
`define OPC_LU12I_W   7'h0a
`define OPC_BL        6'h15
`define OPC_BEQ       6'h16
`define OPC_BNE       6'h17

`endif
